// File: ncpu_ieu.f
ncpu_isa_pkg.sv
ncpu_ieu_pkg.sv
ncpu_ie_au.sv
ncpu_ie_lu.sv
ncpu_ie_wb.sv
ncpu_ie_flush.sv
ncpu_ieu.sv
tb_clk_gen.sv
tb_ncpu_ieu.sv

// File: tb_ncpu_ieu.sv
//==========================================================
// Testbench for the integer execution stage
// Random ALU, compare and jump stimulus, flush acknowledge
// responder, reference checks as concurrent assertions
//==========================================================
`timescale 1ns/1ps

module tb_ncpu_ieu;

   import ncpu_isa_pkg::*;
   import ncpu_ieu_pkg::*;

   localparam int DATA_W  = 32;
   localparam int N_ALU   = 240;
   localparam int N_CMP   = 80;
   localparam int N_JMP   = 120;
   localparam int MAX_ACK = 4;
   localparam int TIMEOUT = 3 * (N_ALU + N_CMP + N_JMP) + (MAX_ACK + 1) * N_JMP + 100;

   logic              clk;
   logic              rst_n;
   logic              in_valid;
   logic              in_ready;
   logic [DATA_W-1:0] operand_1;
   logic [DATA_W-1:0] operand_2;
   logic [DATA_W-1:0] epc;
   issue_ctrl_t       ctrl;
   specul_t           specul;
   logic              psr_cc;
   logic              flush_ack;
   logic              regf_we;
   logic [REG_AW-1:0] regf_din_addr;
   logic [DATA_W-1:0] regf_din;
   logic              psr_cc_we;
   logic              psr_cc_nxt;
   ifu_flush_t        ifu_flush;
   bpu_wb_t           bpu_wb;

   logic [31:0]       seed = 32'h78526c39;
   int                errors;
   int                n_insn;
   int                n_flush;
   int                cycles;
   int                ack_wait;
   logic              pend;        // Model of a flush waiting for ack
   pc_t               pend_tgt;
   logic              exp_ready;
   logic              commit_m;
   logic              exp_flush;
   pc_t               exp_tgt;
   logic [DATA_W-1:0] exp_din;
   logic              exp_cc;

   tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

   ncpu_ieu #(.DATA_W(DATA_W)) u_ncpu_ieu (
      .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
      .operand_1(operand_1), .operand_2(operand_2), .epc(epc), .ctrl(ctrl),
      .specul(specul), .psr_cc(psr_cc), .flush_ack(flush_ack), .regf_we(regf_we),
      .regf_din_addr(regf_din_addr), .regf_din(regf_din), .psr_cc_we(psr_cc_we),
      .psr_cc_nxt(psr_cc_nxt), .ifu_flush(ifu_flush), .bpu_wb(bpu_wb)
   );

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      errors++;
      $display("[ERROR] %s expected %h actual %h", name, exp_v, act_v);
   endtask

   // Reference rules for the stage
   assign exp_ready = !pend || flush_ack;
   assign commit_m  = in_valid && exp_ready;

   always_comb begin
      exp_flush = commit_m && ((specul.jmprel && (specul.bcc != psr_cc)) ||
                  (specul.jmpfar && (specul.tgt != operand_1[31:2])) || specul.ret);
      if (specul.jmprel)      exp_tgt = specul.tgt;
      else if (specul.jmpfar) exp_tgt = operand_1[31:2];
      else                    exp_tgt = epc[31:2];
      if (ctrl.au_op.cmp_eq)          exp_cc = (operand_1 == operand_2);
      else if (ctrl.au_op.cmp_signed) exp_cc = ($signed(operand_1) < $signed(operand_2));
      else                            exp_cc = (operand_1 < operand_2);
      exp_din = '0;
      if (ctrl.jmplink)     exp_din = (32'(specul.insn_pc) + 32'd1) * 32'd4;
      if (ctrl.au_op.add)   exp_din = operand_1 + operand_2;
      if (ctrl.au_op.sub)   exp_din = operand_1 - operand_2;
      if (ctrl.lu_op.and_op) exp_din = operand_1 & operand_2;
      if (ctrl.lu_op.or_op)  exp_din = operand_1 | operand_2;
      if (ctrl.lu_op.xor_op) exp_din = operand_1 ^ operand_2;
      if (ctrl.lu_op.shl)   exp_din = operand_1 << operand_2[4:0];
      if (ctrl.lu_op.shr)   exp_din = operand_1 >> operand_2[4:0];
      if (ctrl.lu_op.sar)   exp_din = $signed(operand_1) >>> operand_2[4:0];
   end

   // Flush held from the commit edge until the ack cycle
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pend     <= 1'b0;
         pend_tgt <= '0;
      end else begin
         pend <= exp_flush || (pend && !flush_ack);
         if (exp_flush) begin
            pend_tgt <= exp_tgt;
            n_flush++;
         end
         if (commit_m) n_insn++;
      end
   end

   a_ready: assert property (@(posedge clk) disable iff (!rst_n) in_ready == exp_ready)
      else report_mismatch("in_ready", $sampled(exp_ready), $sampled(in_ready));
   a_regf_we: assert property (@(posedge clk) disable iff (!rst_n)
      regf_we == (commit_m && ctrl.wb_regf))
      else report_mismatch("regf_we", $sampled(commit_m && ctrl.wb_regf), $sampled(regf_we));
   a_regf_addr: assert property (@(posedge clk) disable iff (!rst_n)
      regf_we |-> regf_din_addr == ctrl.wb_reg_addr)
      else report_mismatch("regf_din_addr", $sampled(ctrl.wb_reg_addr), $sampled(regf_din_addr));
   a_regf_din: assert property (@(posedge clk) disable iff (!rst_n)
      regf_we |-> regf_din == exp_din)
      else report_mismatch("regf_din", $sampled(exp_din), $sampled(regf_din));
   a_cc_we: assert property (@(posedge clk) disable iff (!rst_n)
      psr_cc_we == (commit_m && ctrl.au_op.cmp))
      else report_mismatch("psr_cc_we", $sampled(commit_m && ctrl.au_op.cmp), $sampled(psr_cc_we));
   a_cc_nxt: assert property (@(posedge clk) disable iff (!rst_n)
      psr_cc_we |-> psr_cc_nxt == exp_cc)
      else report_mismatch("psr_cc_nxt", $sampled(exp_cc), $sampled(psr_cc_nxt));
   a_flush_req: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_flush.req == (pend || exp_flush))
      else report_mismatch("ifu_flush.req", $sampled(pend || exp_flush), $sampled(ifu_flush.req));
   a_flush_tgt: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_flush.req |-> ifu_flush.tgt == (pend ? pend_tgt : exp_tgt))
      else report_mismatch("ifu_flush.tgt", $sampled(pend ? pend_tgt : exp_tgt),
                           $sampled(ifu_flush.tgt));
   a_bpu_valid: assert property (@(posedge clk) disable iff (!rst_n)
      bpu_wb.valid == (commit_m && (specul.jmprel || specul.jmpfar)))
      else report_mismatch("bpu_wb.valid", $sampled(commit_m && (specul.jmprel || specul.jmpfar)),
                           $sampled(bpu_wb.valid));
   a_bpu_hit: assert property (@(posedge clk) disable iff (!rst_n)
      bpu_wb.valid |-> bpu_wb.hit == !exp_flush)
      else report_mismatch("bpu_wb.hit", $sampled(!exp_flush), $sampled(bpu_wb.hit));
   a_bpu_jmprel: assert property (@(posedge clk) disable iff (!rst_n)
      bpu_wb.valid |-> bpu_wb.jmprel == specul.jmprel)
      else report_mismatch("bpu_wb.jmprel", $sampled(specul.jmprel), $sampled(bpu_wb.jmprel));
   a_bpu_pc: assert property (@(posedge clk) disable iff (!rst_n)
      bpu_wb.valid |-> bpu_wb.insn_pc == specul.insn_pc)
      else report_mismatch("bpu_wb.insn_pc", $sampled(specul.insn_pc),
                           $sampled(bpu_wb.insn_pc));

   // Fetch unit model, acks each flush after a varying delay
   initial begin
      flush_ack = 1'b0;
      ack_wait  = 0;
      forever begin
         @(negedge clk);
         if (flush_ack) begin
            flush_ack = 1'b0;
            ack_wait  = 0;
         end else if (pend) begin
            if (ack_wait >= n_flush % MAX_ACK) flush_ack = 1'b1;
            else ack_wait++;
         end
      end
   end

   task automatic issue_insn(input issue_ctrl_t c, input logic [31:0] a,
                             input logic [31:0] b, input specul_t s);
      logic [31:0] r;
      @(negedge clk);
      r         = next_rand();
      ctrl      = c;
      operand_1 = a;
      operand_2 = b;
      specul    = s;
      psr_cc    = r[17];
      epc       = next_rand();
      in_valid  = 1'b1;
      @(posedge clk);
      while (!in_ready) @(posedge clk);   // Stalled by a pending flush
   endtask

   initial begin
      issue_ctrl_t c;
      specul_t     s;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      in_valid  = 1'b0;
      operand_1 = '0;
      operand_2 = '0;
      epc       = '0;
      ctrl      = '0;
      specul    = '0;
      psr_cc    = 1'b0;
      @(posedge rst_n);
      repeat (3) @(posedge clk);   // Idle outputs checked by the assertions
      for (int i = 0; i < N_ALU + N_CMP + N_JMP; i++) begin
         r = next_rand();
         a = next_rand();
         b = next_rand();
         c = '0;
         s = '0;
         s.insn_pc = pc_t'(next_rand());
         s.tgt     = pc_t'(next_rand());
         c.wb_reg_addr = r[15:11];
         if (i < N_ALU) begin
            c.wb_regf = 1'b1;
            case (r % 8)
               0: c.au_op.add    = 1'b1;
               1: c.au_op.sub    = 1'b1;
               2: c.lu_op.and_op = 1'b1;
               3: c.lu_op.or_op  = 1'b1;
               4: c.lu_op.xor_op = 1'b1;
               5: c.lu_op.shl    = 1'b1;
               6: c.lu_op.shr    = 1'b1;
               default: c.lu_op.sar = 1'b1;
            endcase
         end else if (i < N_ALU + N_CMP) begin
            c.au_op.cmp        = 1'b1;
            c.au_op.cmp_eq     = (r[3:2] == 2'b00);
            c.au_op.cmp_signed = r[4];
            if (r[5]) b = a;   // Equal operands now and then
         end else begin
            case (r % 3)
               0: begin
                  s.jmprel = 1'b1;
                  s.bcc    = r[8];
               end
               1: begin
                  s.jmpfar  = 1'b1;
                  c.jmplink = r[10];
                  c.wb_regf = r[10];
                  if (r[9]) s.tgt = a[31:2];
               end
               default: s.ret = 1'b1;
            endcase
         end
         issue_insn(c, a, b, s);
      end
      @(negedge clk);
      in_valid = 1'b0;
      @(posedge clk);
      while (!in_ready) @(posedge clk);
      repeat (4) @(posedge clk);
      $display("Summary: %0d instructions, %0d flushes, %0d errors", n_insn, n_flush, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
         $display("test failed");
         $finish;
      end
   end

endmodule

// File: tb_clk_gen.sv
//==========================================================
// Testbench clock and reset generator
// 10 ns clock, active-low reset held for 4 cycles
//==========================================================
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int HALF_NS    = 5,
   parameter int RST_CYCLES = 4
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(HALF_NS) clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);   // Release away from the active edge
      rst_n = 1'b1;
   end

endmodule

// File: ncpu_ieu.sv
//==========================================================
// Integer execution stage top level
// Issue handshake, AU, LU, write-back and flush unit
//==========================================================
`timescale 1ns/1ps

module ncpu_ieu #(
   parameter int DATA_W = 32
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              in_valid,
   output logic                              in_ready,
   input  logic [DATA_W-1:0]                 operand_1,
   input  logic [DATA_W-1:0]                 operand_2,
   input  logic [DATA_W-1:0]                 epc,
   input  ncpu_isa_pkg::issue_ctrl_t         ctrl,
   input  ncpu_ieu_pkg::specul_t             specul,
   input  logic                              psr_cc,
   input  logic                              flush_ack,
   output logic                              regf_we,
   output logic [ncpu_isa_pkg::REG_AW-1:0]   regf_din_addr,
   output logic [DATA_W-1:0]                 regf_din,
   output logic                              psr_cc_we,
   output logic                              psr_cc_nxt,
   output ncpu_ieu_pkg::ifu_flush_t          ifu_flush,
   output ncpu_ieu_pkg::bpu_wb_t             bpu_wb
);

   import ncpu_ieu_pkg::*;

   logic              commit;
   logic              flush_hold;
   pc_t               jmpfar_tgt;
   pc_t               epc_tgt;
   logic [DATA_W-1:0] au_adder;
   logic              au_op_adder;
   logic [DATA_W-1:0] lu_bitwise;
   logic              lu_op_bitwise;
   logic [DATA_W-1:0] lu_shift;
   logic              lu_op_shift;

   assign commit   = in_valid & in_ready;
   assign in_ready = ~flush_hold;   // Stalls only on a pending flush

   // Word-address bits, no alignment check
   assign jmpfar_tgt = operand_1[PC_W+1:2];
   assign epc_tgt    = epc[PC_W+1:2];

   ncpu_ie_au #(.DATA_W(DATA_W)) u_au (
      .operand_1 (operand_1),
      .operand_2 (operand_2),
      .au_op     (ctrl.au_op),
      .commit    (commit),
      .adder     (au_adder),
      .op_adder  (au_op_adder),
      .cc_we     (psr_cc_we),
      .cc_nxt    (psr_cc_nxt)
   );

   ncpu_ie_lu #(.DATA_W(DATA_W)) u_lu (
      .operand_1  (operand_1),
      .operand_2  (operand_2),
      .lu_op      (ctrl.lu_op),
      .bitwise    (lu_bitwise),
      .op_bitwise (lu_op_bitwise),
      .shift      (lu_shift),
      .op_shift   (lu_op_shift)
   );

   ncpu_ie_wb #(.DATA_W(DATA_W)) u_wb (
      .commit        (commit),
      .ctrl          (ctrl),
      .insn_pc       (specul.insn_pc),
      .adder         (au_adder),
      .bitwise       (lu_bitwise),
      .shift         (lu_shift),
      .op_adder      (au_op_adder),
      .op_bitwise    (lu_op_bitwise),
      .op_shift      (lu_op_shift),
      .regf_we       (regf_we),
      .regf_din_addr (regf_din_addr),
      .regf_din      (regf_din)
   );

   ncpu_ie_flush u_flush (
      .clk        (clk),
      .rst_n      (rst_n),
      .commit     (commit),
      .specul     (specul),
      .jmpfar_tgt (jmpfar_tgt),
      .psr_cc     (psr_cc),
      .epc_tgt    (epc_tgt),
      .flush_ack  (flush_ack),
      .ifu_flush  (ifu_flush),
      .flush_hold (flush_hold),
      .bpu_wb     (bpu_wb)
   );

   // Target slices and the link address need a full word address
   a_data_w: assert property (@(posedge clk) DATA_W >= PC_W + 2)
      else $error("DATA_W %0d too narrow for PC_W %0d", DATA_W, PC_W);

endmodule

// File: ncpu_ie_flush.sv
//==========================================================
// Speculation check at commit
// Flush FSM with acknowledge bypass, predictor
// write-back, flush target mux check
//==========================================================
`timescale 1ns/1ps

module ncpu_ie_flush (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     commit,
   input  ncpu_ieu_pkg::specul_t    specul,
   input  ncpu_ieu_pkg::pc_t        jmpfar_tgt,
   input  logic                     psr_cc,
   input  ncpu_ieu_pkg::pc_t        epc_tgt,
   input  logic                     flush_ack,
   output ncpu_ieu_pkg::ifu_flush_t ifu_flush,
   output logic                     flush_hold,
   output ncpu_ieu_pkg::bpu_wb_t    bpu_wb
);

   import ncpu_ieu_pkg::*;

   logic fls_status_r;   // Latched flush waiting for ack
   logic fls_status_nxt;
   logic ld_fls;
   logic flush_nxt;
   pc_t  tgt_nxt;
   logic req_r;
   pc_t  tgt_r;

   // Mispredicted branch, wrong far target, or return
   assign flush_nxt = commit &
      ((specul.jmprel & (specul.bcc != psr_cc)) |
       (specul.jmpfar & (specul.tgt != jmpfar_tgt)) |
       specul.ret);

   assign tgt_nxt = ({PC_W{specul.jmprel}} & specul.tgt) |
                    ({PC_W{specul.jmpfar}} & jmpfar_tgt) |
                    ({PC_W{specul.ret}}    & epc_tgt);

   // An ack frees the register, a commit in that cycle may refill it
   assign ld_fls = ~fls_status_r | flush_ack;

   always_comb begin
      if (fls_status_r) begin
         fls_status_nxt = flush_ack ? flush_nxt : 1'b1;
      end else begin
         fls_status_nxt = flush_nxt & ~flush_ack;   // Acked at once
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fls_status_r <= 1'b0;
         req_r        <= 1'b0;
      end else begin
         fls_status_r <= fls_status_nxt;
         if (ld_fls) begin
            req_r <= flush_nxt;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ld_fls) begin
         tgt_r <= tgt_nxt;
      end
   end

   assign flush_hold = fls_status_r & ~flush_ack;

   // Latched request stays visible in the ack cycle
   always_comb begin
      if (fls_status_r) begin
         ifu_flush.req = req_r;
         ifu_flush.tgt = tgt_r;
      end else begin
         ifu_flush.req = flush_nxt;
         ifu_flush.tgt = tgt_nxt;
      end
   end

   assign bpu_wb.valid   = commit & (specul.jmprel | specul.jmpfar);
   assign bpu_wb.jmprel  = specul.jmprel;
   assign bpu_wb.hit     = ~flush_nxt;   // This instruction's own outcome
   assign bpu_wb.insn_pc = specul.insn_pc;

   a_tgt_mux_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      commit |-> $onehot0({specul.jmprel, specul.jmpfar, specul.ret}))
      else $error("Flush target selects not one-hot");

endmodule

// File: ncpu_ie_wb.sv
//==========================================================
// Write-back unit
// Link address, one-hot result mux, register write
// enable and source mutex check
//==========================================================
`timescale 1ns/1ps

module ncpu_ie_wb #(
   parameter int DATA_W = 32
) (
   input  logic                              commit,
   input  ncpu_isa_pkg::issue_ctrl_t         ctrl,
   input  ncpu_ieu_pkg::pc_t                 insn_pc,
   input  logic [DATA_W-1:0]                 adder,
   input  logic [DATA_W-1:0]                 bitwise,
   input  logic [DATA_W-1:0]                 shift,
   input  logic                              op_adder,
   input  logic                              op_bitwise,
   input  logic                              op_shift,
   output logic                              regf_we,
   output logic [ncpu_isa_pkg::REG_AW-1:0]   regf_din_addr,
   output logic [DATA_W-1:0]                 regf_din
);

   import ncpu_isa_pkg::*;
   import ncpu_ieu_pkg::*;

   pc_t               link_pc;
   logic [DATA_W-1:0] linkaddr;
   wb_src_t           src_sel;
   logic [DATA_W-1:0] src_data [WB_SRC_N];

   // Instruction after the jump, as a byte address
   assign link_pc  = insn_pc + 1'b1;
   assign linkaddr = DATA_W'({link_pc, 2'b00});

   assign src_sel[WB_SRC_ADDER]   = op_adder;
   assign src_sel[WB_SRC_BITWISE] = op_bitwise;
   assign src_sel[WB_SRC_SHIFT]   = op_shift;
   assign src_sel[WB_SRC_LINK]    = ctrl.jmplink;

   assign src_data[WB_SRC_ADDER]   = adder;
   assign src_data[WB_SRC_BITWISE] = bitwise;
   assign src_data[WB_SRC_SHIFT]   = shift;
   assign src_data[WB_SRC_LINK]    = linkaddr;

   // AND-OR mux, selects must be one-hot
   always_comb begin
      regf_din = '0;
      for (int i = 0; i < WB_SRC_N; i++) begin
         regf_din = regf_din | ({DATA_W{src_sel[i]}} & src_data[i]);
      end
   end

   assign regf_we       = commit & ctrl.wb_regf;
   assign regf_din_addr = ctrl.wb_reg_addr;

   // Selects come from both AU and LU decoding
   a_wb_src_mutex: assert final (!regf_we || $onehot0(src_sel))
      else $error("Write-back sources not mutex: sel %h", src_sel);

endmodule

// File: ncpu_ie_lu.sv
//==========================================================
// Logic unit
// Bitwise and/or/xor, left, logical right and
// arithmetic right shift
//==========================================================
`timescale 1ns/1ps

module ncpu_ie_lu #(
   parameter int DATA_W = 32
) (
   input  logic [DATA_W-1:0]    operand_1,
   input  logic [DATA_W-1:0]    operand_2,
   input  ncpu_isa_pkg::lu_op_t lu_op,
   output logic [DATA_W-1:0]    bitwise,
   output logic                 op_bitwise,
   output logic [DATA_W-1:0]    shift,
   output logic                 op_shift
);

   localparam int SH_W = $clog2(DATA_W);

   logic [SH_W-1:0]   shamt;
   logic [DATA_W-1:0] shl_res;
   logic [DATA_W-1:0] shr_res;
   logic [DATA_W-1:0] sar_res;

   assign shamt = operand_2[SH_W-1:0];   // Upper bits ignored

   assign op_bitwise = lu_op.and_op | lu_op.or_op | lu_op.xor_op;
   assign op_shift   = lu_op.shl | lu_op.shr | lu_op.sar;

   // One-hot AND-OR select
   assign bitwise = ({DATA_W{lu_op.and_op}} & (operand_1 & operand_2)) |
                    ({DATA_W{lu_op.or_op}}  & (operand_1 | operand_2)) |
                    ({DATA_W{lu_op.xor_op}} & (operand_1 ^ operand_2));

   assign shl_res = operand_1 << shamt;
   assign shr_res = operand_1 >> shamt;
   assign sar_res = $signed(operand_1) >>> shamt;   // Sign fill

   assign shift = ({DATA_W{lu_op.shl}} & shl_res) |
                  ({DATA_W{lu_op.shr}} & shr_res) |
                  ({DATA_W{lu_op.sar}} & sar_res);

endmodule

// File: ncpu_ie_au.sv
//==========================================================
// Adder unit
// Shared add/subtract, equal and less-than compare,
// condition-flag update
//==========================================================
`timescale 1ns/1ps

module ncpu_ie_au #(
   parameter int DATA_W = 32
) (
   input  logic [DATA_W-1:0]    operand_1,
   input  logic [DATA_W-1:0]    operand_2,
   input  ncpu_isa_pkg::au_op_t au_op,
   input  logic                 commit,
   output logic [DATA_W-1:0]    adder,
   output logic                 op_adder,
   output logic                 cc_we,
   output logic                 cc_nxt
);

   logic              subtract;
   logic [DATA_W-1:0] addend;
   logic [DATA_W:0]   sum;
   logic              cmp_eq_res;
   logic              cmp_ult;
   logic              cmp_slt;
   logic              sign_diff;

   // Compare reuses the subtractor
   assign subtract = au_op.sub | au_op.cmp;
   assign addend   = subtract ? ~operand_2 : operand_2;

   assign sum = {1'b0, operand_1} + {1'b0, addend} + {{DATA_W{1'b0}}, subtract};

   assign adder    = sum[DATA_W-1:0];
   assign op_adder = au_op.add | au_op.sub;

   // No carry out of op1 + ~op2 + 1 means a borrow
   assign cmp_eq_res = ~|sum[DATA_W-1:0];
   assign cmp_ult    = ~sum[DATA_W];

   // Differing signs decide directly, else same as unsigned
   assign sign_diff = operand_1[DATA_W-1] ^ operand_2[DATA_W-1];
   assign cmp_slt   = sign_diff ? operand_1[DATA_W-1] : cmp_ult;

   assign cc_we = commit & au_op.cmp;

   always_comb begin
      if (au_op.cmp_eq) begin
         cc_nxt = cmp_eq_res;
      end else if (au_op.cmp_signed) begin
         cc_nxt = cmp_slt;
      end else begin
         cc_nxt = cmp_ult;
      end
   end

   // Decoder must never select two adder operations at once,
   // the subtract control and the result mux both rely on it
   a_au_op_onehot: assert final ($onehot0({au_op.add, au_op.sub, au_op.cmp}))
      else $error("AU opcode is not one-hot: add %b sub %b cmp %b",
                  au_op.add, au_op.sub, au_op.cmp);

endmodule

// File: ncpu_ieu_pkg.sv
//==========================================================
// Execution-stage interface definitions
// Program-counter type, front-end speculation bundle,
// fetch flush request and predictor write-back
//==========================================================

package ncpu_ieu_pkg;

   // PC is a word address, the two byte bits are implied
   localparam int PC_W = 30;

   typedef logic [PC_W-1:0] pc_t;

   // Front end's prediction for one issued instruction
   typedef struct packed {
      pc_t  insn_pc;   // Word address of the instruction
      logic jmprel;    // Conditional relative branch
      logic jmpfar;    // Register-indirect jump
      logic ret;       // Return from exception
      logic bcc;       // Predicted branch condition
      pc_t  tgt;       // Predicted or encoded target
   } specul_t;

   // Flush request towards the fetch unit
   typedef struct packed {
      logic req;
      pc_t  tgt;       // Refetch address
   } ifu_flush_t;

   // Branch outcome for the predictor
   typedef struct packed {
      logic valid;
      logic jmprel;
      logic hit;       // Prediction was right
      pc_t  insn_pc;
   } bpu_wb_t;

   // Note that a commit with jmprel and a correct bcc is a hit even
   // if the branch was not taken, the predictor updates its
   // counter from the flag it already holds

endpackage

// File: ncpu_isa_pkg.sv
//==========================================================
// Instruction-set definitions for the execution stage
// AU and LU one-hot opcode structs, decoded issue control,
// write-back source indices
//==========================================================

package ncpu_isa_pkg;

   localparam int REG_AW = 5;   // Register-file address width

   // Adder unit opcode, add/sub/cmp one-hot
   typedef struct packed {
      logic add;
      logic sub;
      logic cmp;
      logic cmp_eq;       // Equality compare, else less-than
      logic cmp_signed;   // Signed less-than
   } au_op_t;

   // Logic unit opcode, one-hot
   typedef struct packed {
      logic and_op;
      logic or_op;
      logic xor_op;
      logic shl;
      logic shr;
      logic sar;
   } lu_op_t;

   // Decoded control of one instruction
   typedef struct packed {
      au_op_t            au_op;
      lu_op_t            lu_op;
      logic              jmplink;      // Write link address
      logic              wb_regf;      // Result goes to register file
      logic [REG_AW-1:0] wb_reg_addr;
   } issue_ctrl_t;

   // Write-back source select, one bit per source
   localparam int WB_SRC_N       = 4;
   localparam int WB_SRC_ADDER   = 0;
   localparam int WB_SRC_BITWISE = 1;
   localparam int WB_SRC_SHIFT   = 2;
   localparam int WB_SRC_LINK    = 3;

   typedef logic [WB_SRC_N-1:0] wb_src_t;

endpackage
